// File: src/zynq_shell_pkg.sv
package zynq_shell_pkg;

   // ------------------------------------------------------------
   // bus widths
   // ------------------------------------------------------------
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_ADDR_W = 5;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // word slot index taken from address bits 4 to 2
   localparam int SLOT_W = AXIL_ADDR_W - 2;

   // FIFO geometry, the count needs one bit more than the pointer
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_CNT_W = 3;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   typedef logic [AXIL_DATA_W-1:0] axil_data_t;
   typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
   typedef logic [1:0]             axil_resp_t;

   localparam axil_resp_t RESP_OKAY   = 2'd0;
   localparam axil_resp_t RESP_SLVERR = 2'd2;

   // ------------------------------------------------------------
   // address map, one 32-bit word per slot
   // ------------------------------------------------------------
   localparam logic [SLOT_W-1:0] ADDR_CSR0    = 3'd0;
   localparam logic [SLOT_W-1:0] ADDR_CSR1    = 3'd1;
   localparam logic [SLOT_W-1:0] ADDR_PEER0   = 3'd2;
   localparam logic [SLOT_W-1:0] ADDR_PEER1   = 3'd3;
   localparam logic [SLOT_W-1:0] ADDR_FIFO_WR = 3'd4;
   localparam logic [SLOT_W-1:0] ADDR_FIFO_RD = 3'd5;
   localparam logic [SLOT_W-1:0] ADDR_FREE    = 3'd6;
   localparam logic [SLOT_W-1:0] ADDR_AVAIL   = 3'd7;

   // everything the master drives
   typedef struct packed {
      axil_addr_t aw_addr;
      logic       aw_valid;
      axil_data_t w_data;
      axil_strb_t w_strb;
      logic       w_valid;
      logic       b_ready;
      axil_addr_t ar_addr;
      logic       ar_valid;
      logic       r_ready;
   } axil_req_t;

   // everything the slave drives
   typedef struct packed {
      logic       aw_ready;
      logic       w_ready;
      axil_resp_t b_resp;
      logic       b_valid;
      logic       ar_ready;
      axil_data_t r_data;
      axil_resp_t r_resp;
      logic       r_valid;
   } axil_rsp_t;

   typedef struct packed {
      axil_data_t csr0;
      axil_data_t csr1;
   } csr_bank_t;

endpackage

// File: src/axil_write_decoder.sv
`timescale 1ns/1ps

module axil_write_decoder
(
   input  logic                       aclk,
   input  logic                       rst_n_i,
   input  zynq_shell_pkg::axil_req_t  req_i,
   output logic                       aw_ready_o,
   output logic                       w_ready_o,
   output logic                       b_valid_o,
   output zynq_shell_pkg::axil_resp_t b_resp_o,
   output zynq_shell_pkg::csr_bank_t  csr_o,
   output logic                       push_o,
   output zynq_shell_pkg::axil_data_t push_data_o,
   input  logic                       fifo_full_i
);
   import zynq_shell_pkg::*;

   logic [SLOT_W-1:0] wr_slot;
   logic              wr_accept;
   logic              fifo_reject;
   csr_bank_t         csr_q;
   logic              b_valid_q;
   axil_resp_t        b_resp_q;

   // replace only the bytes whose strobe is set
   function automatic axil_data_t merge_strb(
      axil_data_t old_word,
      axil_data_t new_word,
      axil_strb_t strb
   );
      axil_data_t merged;
      merged = old_word;
      for (int i = 0; i < AXIL_STRB_W; i++)
      begin
         if (strb[i])
         begin
            merged[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return merged;
   endfunction

   // ------------------------------------------------------------
   // handshake
   // ------------------------------------------------------------
   // address and data are taken together, and only while no response is pending
   assign wr_accept  = req_i.aw_valid & req_i.w_valid & ~b_valid_q;
   assign aw_ready_o = wr_accept;
   assign w_ready_o  = wr_accept;

   assign wr_slot     = req_i.aw_addr[AXIL_ADDR_W-1:2];
   assign fifo_reject = (wr_slot == ADDR_FIFO_WR) & fifo_full_i;

   // a word pushed into a full FIFO is lost, the response tells the master
   assign push_o      = wr_accept & (wr_slot == ADDR_FIFO_WR) & ~fifo_full_i;
   assign push_data_o = req_i.w_data;

   // ------------------------------------------------------------
   // control registers
   // ------------------------------------------------------------
   always_ff @(posedge aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         csr_q <= '0;
      end
      else if (wr_accept)
      begin
         if (wr_slot == ADDR_CSR0)
         begin
            csr_q.csr0 <= merge_strb(csr_q.csr0, req_i.w_data, req_i.w_strb);
         end
         if (wr_slot == ADDR_CSR1)
         begin
            csr_q.csr1 <= merge_strb(csr_q.csr1, req_i.w_data, req_i.w_strb);
         end
      end
   end

   assign csr_o = csr_q;

   // ------------------------------------------------------------
   // write response
   // ------------------------------------------------------------
   always_ff @(posedge aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         b_valid_q <= 1'b0;
      end
      else if (wr_accept)
      begin
         b_valid_q <= 1'b1;
      end
      else if (req_i.b_ready)
      begin
         b_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge aclk)
   begin
      if (wr_accept)
      begin
         b_resp_q <= fifo_reject ? RESP_SLVERR : RESP_OKAY;
      end
   end

   assign b_valid_o = b_valid_q;
   assign b_resp_o  = b_resp_q;

endmodule

// File: src/shell_fifo.sv
`timescale 1ns/1ps

module shell_fifo
(
   input  logic                                  aclk,
   input  logic                                  rst_n_i,
   input  logic                                  push_i,
   input  zynq_shell_pkg::axil_data_t            data_i,
   input  logic                                  pop_i,
   output zynq_shell_pkg::axil_data_t            data_o,
   output logic                                  full_o,
   output logic                                  empty_o,
   output logic [zynq_shell_pkg::FIFO_CNT_W-1:0] count_o
);
   import zynq_shell_pkg::*;

   axil_data_t            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count_q;
   logic                  do_push;
   logic                  do_pop;

   // requests that cannot be served are simply ignored
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge aclk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves the count where it is
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // head word is visible without waiting for a pop
   assign data_o  = mem[rd_ptr];
   assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
   assign empty_o = (count_q == '0);
   assign count_o = count_q;

endmodule

// File: src/axil_read_mux.sv
`timescale 1ns/1ps

module axil_read_mux
(
   input  logic                                  aclk,
   input  logic                                  rst_n_i,
   input  zynq_shell_pkg::axil_req_t             req_i,
   output logic                                  ar_ready_o,
   output logic                                  r_valid_o,
   output zynq_shell_pkg::axil_data_t            r_data_o,
   output zynq_shell_pkg::axil_resp_t            r_resp_o,
   input  zynq_shell_pkg::csr_bank_t             csr_i,
   input  zynq_shell_pkg::csr_bank_t             peer_i,
   input  zynq_shell_pkg::axil_data_t            rd_data_i,
   input  logic                                  rd_empty_i,
   output logic                                  pop_o,
   input  logic [zynq_shell_pkg::FIFO_CNT_W-1:0] free_cnt_i,
   input  logic [zynq_shell_pkg::FIFO_CNT_W-1:0] avail_cnt_i
);
   import zynq_shell_pkg::*;

   logic [SLOT_W-1:0] rd_slot;
   logic              rd_accept;
   axil_data_t        rd_word;
   axil_resp_t        rd_resp;
   logic              r_valid_q;
   axil_data_t        r_data_q;
   axil_resp_t        r_resp_q;

   // one read in flight at a time
   assign ar_ready_o = ~r_valid_q;
   assign rd_accept  = req_i.ar_valid & ~r_valid_q;
   assign rd_slot    = req_i.ar_addr[AXIL_ADDR_W-1:2];

   // ------------------------------------------------------------
   // slot select
   // ------------------------------------------------------------
   always_comb
   begin
      rd_word = '0;
      rd_resp = RESP_OKAY;
      case (rd_slot)
         ADDR_CSR0:  rd_word = csr_i.csr0;
         ADDR_CSR1:  rd_word = csr_i.csr1;
         ADDR_PEER0: rd_word = peer_i.csr0;
         ADDR_PEER1: rd_word = peer_i.csr1;
         ADDR_FIFO_RD:
         begin
            // an empty FIFO answers with zero and an error
            if (rd_empty_i)
            begin
               rd_resp = RESP_SLVERR;
            end
            else
            begin
               rd_word = rd_data_i;
            end
         end
         ADDR_FREE:  rd_word = {{(AXIL_DATA_W - FIFO_CNT_W){1'b0}}, free_cnt_i};
         ADDR_AVAIL: rd_word = {{(AXIL_DATA_W - FIFO_CNT_W){1'b0}}, avail_cnt_i};
         // the FIFO write slot has nothing to show
         default:    rd_word = '0;
      endcase
   end

   assign pop_o = rd_accept & (rd_slot == ADDR_FIFO_RD) & ~rd_empty_i;

   // ------------------------------------------------------------
   // read response
   // ------------------------------------------------------------
   always_ff @(posedge aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         r_valid_q <= 1'b0;
      end
      else if (rd_accept)
      begin
         r_valid_q <= 1'b1;
      end
      else if (req_i.r_ready)
      begin
         r_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge aclk)
   begin
      if (rd_accept)
      begin
         r_data_q <= rd_word;
         r_resp_q <= rd_resp;
      end
   end

   assign r_valid_o = r_valid_q;
   assign r_data_o  = r_data_q;
   assign r_resp_o  = r_resp_q;

endmodule

// File: src/zynq_pl_shell.sv
`timescale 1ns/1ps

module zynq_pl_shell
(
   input  logic                       aclk,
   input  logic                       rst_n_i,
   input  zynq_shell_pkg::axil_req_t  req_i,
   output zynq_shell_pkg::axil_rsp_t  rsp_o,
   output zynq_shell_pkg::axil_data_t ps_to_pl_data_o,
   output logic                       ps_to_pl_v_o,
   input  logic                       ps_to_pl_yumi_i,
   input  zynq_shell_pkg::axil_data_t pl_to_ps_data_i,
   input  logic                       pl_to_ps_v_i,
   output logic                       pl_to_ps_ready_o,
   output zynq_shell_pkg::csr_bank_t  csr_o,
   input  zynq_shell_pkg::csr_bank_t  peer_i
);
   import zynq_shell_pkg::*;

   logic                  push;
   axil_data_t            push_data;
   logic                  ps_to_pl_full;
   logic                  ps_to_pl_empty;
   logic [FIFO_CNT_W-1:0] ps_to_pl_count;
   logic [FIFO_CNT_W-1:0] free_cnt;
   axil_data_t            pl_to_ps_head;
   logic                  pl_to_ps_full;
   logic                  pl_to_ps_empty;
   logic [FIFO_CNT_W-1:0] pl_to_ps_count;
   logic                  pop;

   axil_write_decoder u_wr (
      .aclk        (aclk),
      .rst_n_i     (rst_n_i),
      .req_i       (req_i),
      .aw_ready_o  (rsp_o.aw_ready),
      .w_ready_o   (rsp_o.w_ready),
      .b_valid_o   (rsp_o.b_valid),
      .b_resp_o    (rsp_o.b_resp),
      .csr_o       (csr_o),
      .push_o      (push),
      .push_data_o (push_data),
      .fifo_full_i (ps_to_pl_full)
   );

   // ------------------------------------------------------------
   // ps to pl direction, drained by the accelerator
   // ------------------------------------------------------------
   shell_fifo u_ps_to_pl (
      .aclk    (aclk),
      .rst_n_i (rst_n_i),
      .push_i  (push),
      .data_i  (push_data),
      .pop_i   (ps_to_pl_yumi_i),
      .data_o  (ps_to_pl_data_o),
      .full_o  (ps_to_pl_full),
      .empty_o (ps_to_pl_empty),
      .count_o (ps_to_pl_count)
   );

   assign ps_to_pl_v_o = ~ps_to_pl_empty;
   assign free_cnt     = FIFO_CNT_W'(FIFO_DEPTH) - ps_to_pl_count;

   // ------------------------------------------------------------
   // pl to ps direction, filled by the accelerator
   // ------------------------------------------------------------
   assign pl_to_ps_ready_o = ~pl_to_ps_full;

   shell_fifo u_pl_to_ps (
      .aclk    (aclk),
      .rst_n_i (rst_n_i),
      .push_i  (pl_to_ps_v_i & pl_to_ps_ready_o),
      .data_i  (pl_to_ps_data_i),
      .pop_i   (pop),
      .data_o  (pl_to_ps_head),
      .full_o  (pl_to_ps_full),
      .empty_o (pl_to_ps_empty),
      .count_o (pl_to_ps_count)
   );

   axil_read_mux u_rd (
      .aclk        (aclk),
      .rst_n_i     (rst_n_i),
      .req_i       (req_i),
      .ar_ready_o  (rsp_o.ar_ready),
      .r_valid_o   (rsp_o.r_valid),
      .r_data_o    (rsp_o.r_data),
      .r_resp_o    (rsp_o.r_resp),
      .csr_i       (csr_o),
      .peer_i      (peer_i),
      .rd_data_i   (pl_to_ps_head),
      .rd_empty_i  (pl_to_ps_empty),
      .pop_o       (pop),
      .free_cnt_i  (free_cnt),
      .avail_cnt_i (pl_to_ps_count)
   );

endmodule

// File: src/top_zynq.sv
`timescale 1ns/1ps

module top_zynq
(
   input  logic                      aclk,
   input  logic                      rst_n_i,
   input  zynq_shell_pkg::axil_req_t gp0_req_i,
   output zynq_shell_pkg::axil_rsp_t gp0_rsp_o,
   input  zynq_shell_pkg::axil_req_t gp1_req_i,
   output zynq_shell_pkg::axil_rsp_t gp1_rsp_o
);
   import zynq_shell_pkg::*;

   // index 0 belongs to the gp0 shell, index 1 to gp1
   axil_data_t [1:0] ps_to_pl_data;
   logic       [1:0] ps_to_pl_v;
   logic       [1:0] ps_to_pl_yumi;
   axil_data_t [1:0] pl_to_ps_data;
   logic       [1:0] pl_to_ps_v;
   logic       [1:0] pl_to_ps_ready;
   csr_bank_t  [1:0] csr;

   zynq_pl_shell shell0 (
      .aclk             (aclk),
      .rst_n_i          (rst_n_i),
      .req_i            (gp0_req_i),
      .rsp_o            (gp0_rsp_o),
      .ps_to_pl_data_o  (ps_to_pl_data[0]),
      .ps_to_pl_v_o     (ps_to_pl_v[0]),
      .ps_to_pl_yumi_i  (ps_to_pl_yumi[0]),
      .pl_to_ps_data_i  (pl_to_ps_data[0]),
      .pl_to_ps_v_i     (pl_to_ps_v[0]),
      .pl_to_ps_ready_o (pl_to_ps_ready[0]),
      .csr_o            (csr[0]),
      .peer_i           (csr[1])
   );

   zynq_pl_shell shell1 (
      .aclk             (aclk),
      .rst_n_i          (rst_n_i),
      .req_i            (gp1_req_i),
      .rsp_o            (gp1_rsp_o),
      .ps_to_pl_data_o  (ps_to_pl_data[1]),
      .ps_to_pl_v_o     (ps_to_pl_v[1]),
      .ps_to_pl_yumi_i  (ps_to_pl_yumi[1]),
      .pl_to_ps_data_i  (pl_to_ps_data[1]),
      .pl_to_ps_v_i     (pl_to_ps_v[1]),
      .pl_to_ps_ready_o (pl_to_ps_ready[1]),
      .csr_o            (csr[1]),
      .peer_i           (csr[0])
   );

   // ------------------------------------------------------------
   // stand-in accelerator
   // ------------------------------------------------------------
   // each port's outgoing FIFO loops into the other port's incoming FIFO;
   // a word leaves its source only when the destination takes it
   for (genvar k = 0; k < 2; k++)
   begin : g_cross
      assign pl_to_ps_data[k] = ps_to_pl_data[1-k];
      assign pl_to_ps_v[k]    = ps_to_pl_v[1-k];
      assign ps_to_pl_yumi[k] = pl_to_ps_v[1-k] & pl_to_ps_ready[1-k];
   end

endmodule

// File: verification/top_zynq_checker.sv
`timescale 1ns/1ps

module top_zynq_checker
(
   input logic                                       aclk,
   input logic                                       rst_n_i,
   input zynq_shell_pkg::axil_req_t [1:0]            req_i,
   input zynq_shell_pkg::axil_rsp_t [1:0]            rsp_i,
   input logic [1:0]                                 fifo_push_i,
   input logic [1:0]                                 fifo_pop_i,
   input logic [3:0][zynq_shell_pkg::FIFO_CNT_W-1:0] fifo_cnt_i
);
   import zynq_shell_pkg::*;

   logic [1:0]               b_wait;
   logic [1:0]               r_wait;
   logic [1:0][FIFO_CNT_W:0] in_flight;
   logic [1:0][FIFO_CNT_W:0] flight_next;
   int                       b_fail_cnt = 0;
   int                       r_fail_cnt = 0;
   int                       push_fail_cnt = 0;
   int                       rst_fail_cnt = 0;
   int                       fail_cnt;

   // a response is waiting when it is valid and the master is not ready
   assign b_wait = {rsp_i[1].b_valid & ~req_i[1].b_ready, rsp_i[0].b_valid & ~req_i[0].b_ready};
   assign r_wait = {rsp_i[1].r_valid & ~req_i[1].r_ready, rsp_i[0].r_valid & ~req_i[0].r_ready};

   // words written on port k sit in shell k's outgoing FIFO or in the other shell's incoming one
   assign in_flight[0] = {1'b0, fifo_cnt_i[0]} + {1'b0, fifo_cnt_i[3]};
   assign in_flight[1] = {1'b0, fifo_cnt_i[2]} + {1'b0, fifo_cnt_i[1]};

   // only a bus write adds a word and only a bus read on the other port removes one
   assign flight_next[0] = in_flight[0] + (FIFO_CNT_W + 1)'(fifo_push_i[0])
                           - (FIFO_CNT_W + 1)'(fifo_pop_i[1]);
   assign flight_next[1] = in_flight[1] + (FIFO_CNT_W + 1)'(fifo_push_i[1])
                           - (FIFO_CNT_W + 1)'(fifo_pop_i[0]);

   assign fail_cnt = b_fail_cnt + r_fail_cnt + push_fail_cnt + rst_fail_cnt;

   // ------------------------------------------------------------
   // response channels
   // ------------------------------------------------------------
   assert property (@(posedge aclk) disable iff (!rst_n_i)
      (!$past(b_wait[0]) || (rsp_i[0].b_valid && $stable(rsp_i[0].b_resp))) &&
      (!$past(b_wait[1]) || (rsp_i[1].b_valid && $stable(rsp_i[1].b_resp))))
   else
   begin
      $error("write response changed or dropped before b_ready");
      b_fail_cnt++;
   end

   assert property (@(posedge aclk) disable iff (!rst_n_i)
      (!$past(r_wait[0]) || (rsp_i[0].r_valid && $stable(rsp_i[0].r_data)
                             && $stable(rsp_i[0].r_resp))) &&
      (!$past(r_wait[1]) || (rsp_i[1].r_valid && $stable(rsp_i[1].r_data)
                             && $stable(rsp_i[1].r_resp))))
   else
   begin
      $error("read response changed or dropped before r_ready");
      r_fail_cnt++;
   end

   // ------------------------------------------------------------
   // FIFO safety and reset state
   // ------------------------------------------------------------
   // a word pushed into a full FIFO is lost and breaks this balance
   assert property (@(posedge aclk) disable iff (!rst_n_i)
      (in_flight[0] == $past(flight_next[0])) && (in_flight[1] == $past(flight_next[1])))
   else
   begin
      $error("a FIFO word was lost or duplicated between the ports");
      push_fail_cnt++;
   end

   assert property (@(posedge aclk) !rst_n_i |->
      !rsp_i[0].b_valid && !rsp_i[0].r_valid && !rsp_i[1].b_valid && !rsp_i[1].r_valid)
   else
   begin
      $error("a response was valid during reset");
      rst_fail_cnt++;
   end

endmodule

bind top_zynq top_zynq_checker u_checker (
   .aclk        (aclk),
   .rst_n_i     (rst_n_i),
   .req_i       ({gp1_req_i, gp0_req_i}),
   .rsp_i       ({gp1_rsp_o, gp0_rsp_o}),
   .fifo_push_i ({shell1.u_ps_to_pl.push_i, shell0.u_ps_to_pl.push_i}),
   .fifo_pop_i  ({shell1.u_pl_to_ps.pop_i, shell0.u_pl_to_ps.pop_i}),
   .fifo_cnt_i  ({shell1.u_pl_to_ps.count_o, shell1.u_ps_to_pl.count_o,
                  shell0.u_pl_to_ps.count_o, shell0.u_ps_to_pl.count_o})
);

// File: verification/top_zynq_tb.sv
`timescale 1ns/1ps

module top_zynq_tb;
   import zynq_shell_pkg::*;

   // roughly 100 bus transactions of up to 9 cycles each, with a margin of four
   localparam int MAX_CYCLES = 4000;

   typedef struct packed {
      axil_data_t data;
      axil_resp_t resp;
   } read_result_t;

   logic              aclk;
   logic              rst_n_i;
   axil_req_t         req [2];
   axil_rsp_t         rsp [2];

   // reference model, fifo_model[p] holds the words written on port p
   csr_bank_t         csr_model [2];
   axil_data_t        fifo_model [2][$];
   read_result_t      exp_read [2][$];
   axil_resp_t        exp_bresp [2][$];
   int                rd_checked [2];
   int                wr_checked [2];

   integer            seed = 14853;
   int                cycle_cnt = 0;
   int                data_errors = 0;
   int                resp_errors = 0;
   int                other_errors = 0;
   int                pending;
   int                i;
   logic [SLOT_W-1:0] slot;
   axil_data_t        rnd;
   axil_data_t        d0;
   axil_data_t        d1;

   top_zynq UUT (
      .aclk      (aclk),
      .rst_n_i   (rst_n_i),
      .gp0_req_i (req[0]),
      .gp0_rsp_o (rsp[0]),
      .gp1_req_i (req[1]),
      .gp1_rsp_o (rsp[1])
   );

   initial aclk = 1'b0;
   always #4 aclk = ~aclk;

   always @(posedge aclk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------
   function automatic axil_data_t apply_strobes(axil_data_t old_word, axil_data_t new_word,
                                                axil_strb_t strb);
      axil_data_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   function automatic read_result_t expected_read(int port, logic [SLOT_W-1:0] rd_slot);
      read_result_t res;
      int           held;
      res.data = '0;
      res.resp = RESP_OKAY;
      case (rd_slot)
         ADDR_CSR0:  res.data = csr_model[port].csr0;
         ADDR_CSR1:  res.data = csr_model[port].csr1;
         ADDR_PEER0: res.data = csr_model[1-port].csr0;
         ADDR_PEER1: res.data = csr_model[1-port].csr1;
         ADDR_FIFO_RD:
         begin
            if (fifo_model[1-port].size() == 0)
            begin
               res.resp = RESP_SLVERR;
            end
            else
            begin
               res.data = fifo_model[1-port][0];
            end
         end
         ADDR_FREE:
         begin
            // words beyond what the peer's incoming FIFO takes stay in the outgoing one
            held = fifo_model[port].size() - FIFO_DEPTH;
            res.data = axil_data_t'(FIFO_DEPTH - ((held > 0) ? held : 0));
         end
         ADDR_AVAIL:
         begin
            held = fifo_model[1-port].size();
            res.data = axil_data_t'((held < FIFO_DEPTH) ? held : FIFO_DEPTH);
         end
         default:    res.data = '0;
      endcase
      return res;
   endfunction

   // ------------------------------------------------------------
   // bus tasks
   // ------------------------------------------------------------
   task automatic axil_write(input int port, input logic [SLOT_W-1:0] wr_slot,
                             input axil_data_t data, input axil_strb_t strb);
      int         stall;
      axil_resp_t resp;
      stall = $unsigned($random(seed)) % 3;
      resp  = RESP_OKAY;
      @(negedge aclk);
      req[port].aw_addr  = {wr_slot, 2'b00};
      req[port].aw_valid = 1'b1;
      req[port].w_data   = data;
      req[port].w_strb   = strb;
      req[port].w_valid  = 1'b1;
      @(posedge aclk);
      while (!(rsp[port].aw_ready && rsp[port].w_ready))
      begin
         @(posedge aclk);
      end
      // the model changes at the accepting edge, as the DUT does
      case (wr_slot)
         ADDR_CSR0: csr_model[port].csr0 = apply_strobes(csr_model[port].csr0, data, strb);
         ADDR_CSR1: csr_model[port].csr1 = apply_strobes(csr_model[port].csr1, data, strb);
         ADDR_FIFO_WR:
         begin
            if (fifo_model[port].size() < 2 * FIFO_DEPTH)
            begin
               fifo_model[port].push_back(data);
            end
            else
            begin
               resp = RESP_SLVERR;
            end
         end
         default: resp = RESP_OKAY;
      endcase
      exp_bresp[port].push_back(resp);
      @(negedge aclk);
      req[port].aw_valid = 1'b0;
      req[port].w_valid  = 1'b0;
      repeat (stall) @(negedge aclk);
      req[port].b_ready = 1'b1;
      @(posedge aclk);
      while (!rsp[port].b_valid)
      begin
         @(posedge aclk);
      end
      @(negedge aclk);
      req[port].b_ready = 1'b0;
   endtask

   task automatic axil_read(input int port, input logic [SLOT_W-1:0] rd_slot);
      int stall;
      stall = $unsigned($random(seed)) % 3;
      @(negedge aclk);
      req[port].ar_addr  = {rd_slot, 2'b00};
      req[port].ar_valid = 1'b1;
      @(posedge aclk);
      while (!rsp[port].ar_ready)
      begin
         @(posedge aclk);
      end
      exp_read[port].push_back(expected_read(port, rd_slot));
      if (rd_slot == ADDR_FIFO_RD && fifo_model[1-port].size() > 0)
      begin
         void'(fifo_model[1-port].pop_front());
      end
      @(negedge aclk);
      req[port].ar_valid = 1'b0;
      repeat (stall) @(negedge aclk);
      req[port].r_ready = 1'b1;
      @(posedge aclk);
      while (!rsp[port].r_valid)
      begin
         @(posedge aclk);
      end
      @(negedge aclk);
      req[port].r_ready = 1'b0;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge aclk);
   endtask

   // ------------------------------------------------------------
   // compare
   // ------------------------------------------------------------
   task automatic check_data(input string name, input axil_data_t got, input axil_data_t expected);
      if (got !== expected)
      begin
         $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
         data_errors++;
      end
   endtask

   task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t expected);
      if (got !== expected)
      begin
         $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
         resp_errors++;
      end
   endtask

   always @(posedge aclk)
   begin
      for (int k = 0; k < 2; k++)
      begin
         if (rsp[k].r_valid && req[k].r_ready)
         begin
            if (rd_checked[k] >= exp_read[k].size())
            begin
               $display("gp%0d returned a read response that no read asked for", k);
               other_errors++;
            end
            else
            begin
               check_data($sformatf("gp%0d r_data", k), rsp[k].r_data,
                          exp_read[k][rd_checked[k]].data);
               check_resp($sformatf("gp%0d r_resp", k), rsp[k].r_resp,
                          exp_read[k][rd_checked[k]].resp);
            end
            rd_checked[k]++;
         end
         if (rsp[k].b_valid && req[k].b_ready)
         begin
            if (wr_checked[k] >= exp_bresp[k].size())
            begin
               $display("gp%0d returned a write response that no write asked for", k);
               other_errors++;
            end
            else
            begin
               check_resp($sformatf("gp%0d b_resp", k), rsp[k].b_resp,
                          exp_bresp[k][wr_checked[k]]);
            end
            wr_checked[k]++;
         end
      end
   end

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial
   begin
      req[0]        = '0;
      req[1]        = '0;
      csr_model[0]  = '0;
      csr_model[1]  = '0;
      rd_checked[0] = 0;
      rd_checked[1] = 0;
      wr_checked[0] = 0;
      wr_checked[1] = 0;
      rst_n_i       = 1'b0;
      repeat (16) @(posedge aclk);
      @(negedge aclk);
      rst_n_i = 1'b1;

      // registers with random strobes, read back on the same port
      for (i = 0; i < 16; i++)
      begin
         rnd  = $random(seed);
         slot = (i % 4 < 2) ? ADDR_CSR0 : ADDR_CSR1;
         axil_write(i % 2, slot, $random(seed), rnd[3:0]);
         axil_read(i % 2, slot);
      end

      // peer copies on the other port
      axil_read(0, ADDR_PEER0);
      axil_read(0, ADDR_PEER1);
      axil_read(1, ADDR_PEER0);
      axil_read(1, ADDR_PEER1);
      axil_write(0, ADDR_CSR1, $random(seed), 4'hf);
      axil_read(1, ADDR_PEER1);

      // FIFO words cross in both directions at once
      for (i = 0; i < 6; i++)
      begin
         d0 = $random(seed);
         d1 = $random(seed);
         fork
            axil_write(0, ADDR_FIFO_WR, d0, 4'hf);
            axil_write(1, ADDR_FIFO_WR, d1, 4'hf);
         join
      end
      wait_cycles(3);
      axil_read(0, ADDR_FREE);
      axil_read(1, ADDR_AVAIL);
      for (i = 0; i < 6; i++)
      begin
         fork
            axil_read(0, ADDR_FIFO_RD);
            axil_read(1, ADDR_FIFO_RD);
         join
      end

      // fill both FIFOs of one direction, the ninth word is rejected
      for (i = 0; i < 9; i++)
      begin
         axil_write(0, ADDR_FIFO_WR, $random(seed), 4'hf);
      end
      wait_cycles(3);
      axil_read(0, ADDR_FREE);
      axil_read(1, ADDR_AVAIL);
      axil_read(1, ADDR_FREE);
      for (i = 0; i < 9; i++)
      begin
         axil_read(1, ADDR_FIFO_RD);
      end
      wait_cycles(3);
      axil_read(0, ADDR_FREE);
      axil_read(0, ADDR_FIFO_RD);

      // read-only and unused slots ignore writes
      for (i = 2; i < 8; i++)
      begin
         slot = i[SLOT_W-1:0];
         if (slot != ADDR_FIFO_WR)
         begin
            axil_write(1, slot, $random(seed), 4'hf);
         end
      end
      wait_cycles(3);
      for (i = 0; i < 8; i++)
      begin
         axil_read(0, i[SLOT_W-1:0]);
         axil_read(1, i[SLOT_W-1:0]);
      end

      wait_cycles(3);
      pending = exp_read[0].size() - rd_checked[0] + exp_read[1].size() - rd_checked[1]
                + exp_bresp[0].size() - wr_checked[0] + exp_bresp[1].size() - wr_checked[1];
      $display("errors: data %0d, resp %0d, other %0d, unanswered %0d, assertion %0d",
               data_errors, resp_errors, other_errors, pending, UUT.u_checker.fail_cnt);
      if (data_errors + resp_errors + other_errors + pending + UUT.u_checker.fail_cnt == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: list.f
src/zynq_shell_pkg.sv
src/axil_write_decoder.sv
src/shell_fifo.sv
src/axil_read_mux.sv
src/zynq_pl_shell.sv
src/top_zynq.sv
verification/top_zynq_checker.sv
verification/top_zynq_tb.sv

// File: Makefile
TOP := top_zynq_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir
